//--- Makefile
VERILATOR ?= verilator
TOP ?= sadEngineTb
FILELIST ?= sadEngine.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -Wno-fatal

SOURCES := $(wildcard rtl/*.sv tb/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/sadApbControl.sv
`timescale 1ns/1ps

module sadApbControl #(
        parameter int ElemWidth = 8
) (
        input  logic Clk,
        input  logic rst,

        // APB slave, zero wait states
        input  logic psel,
        input  logic penable,
        input  logic pwrite,
        input  sadPkg::apbAddrT paddr,
        input  sadPkg::apbDataT pwdata,
        output sadPkg::apbDataT prdata,

        // Tracker readback
        input  logic [ElemWidth+3:0] lastSad,
        input  logic [ElemWidth+3:0] bestSad,
        input  sadPkg::frameIndexT bestIdx,
        input  sadPkg::frameIndexT resultCount,

        // To the datapath
        output logic [sadPkg::NumElems*ElemWidth-1:0] stageVec,
        output sadPkg::loadKindT loadKind,
        output logic clearBest
);

        import sadPkg::*;

        localparam int PtrWidth = $clog2(NumElems);

        logic wrEn;
        logic cmdWrite;
        logic elemWrite;
        logic countWrite;

        logic [ElemWidth-1:0] stageMem [NumElems];
        logic [PtrWidth-1:0] stagePtr;

        ////////////////////////////////////////
        // Write decode
        ////////////////////////////////////////

        // Access phase completes on the same edge
        assign wrEn = psel & penable & pwrite;

        assign cmdWrite = wrEn && (paddr == AddrCmd);
        assign elemWrite = wrEn && (paddr == AddrElem);
        assign countWrite = wrEn && (paddr == AddrCount);

        ////////////////////////////////////////
        // Staging buffer
        ////////////////////////////////////////

        always_ff @(posedge Clk) begin
                if (elemWrite) begin
                        stageMem[stagePtr] <= pwdata[ElemWidth-1:0];
                end
        end

        // Pointer wraps at NumElems, restarts on each command
        always_ff @(posedge Clk) begin
                if (rst) begin
                        stagePtr <= '0;
                end else if (cmdWrite) begin
                        stagePtr <= '0;
                end else if (elemWrite) begin
                        stagePtr <= stagePtr + 1'b1;
                end
        end

        // Element 0 sits in the low bits
        for (genvar i = 0; i < NumElems; i++) begin : genFlatten
                assign stageVec[i*ElemWidth +: ElemWidth] = stageMem[i];
        end

        ////////////////////////////////////////
        // Command and clear strobes
        ////////////////////////////////////////

        // One cycle each, kindNone when idle
        always_ff @(posedge Clk) begin
                if (rst) begin
                        loadKind <= kindNone;
                        clearBest <= 1'b0;
                end else begin
                        if (cmdWrite) begin
                                loadKind <= loadKindT'(pwdata[1:0]);
                        end else begin
                                loadKind <= kindNone;
                        end
                        clearBest <= countWrite;
                end
        end

        ////////////////////////////////////////
        // Readback mux
        ////////////////////////////////////////

        // Zero-extended to the bus width
        always_comb begin
                case (paddr)
                        AddrCount: begin
                                prdata = apbDataT'(resultCount);
                        end
                        AddrLast: begin
                                prdata = apbDataT'(lastSad);
                        end
                        AddrBest: begin
                                prdata = apbDataT'(bestSad);
                        end
                        AddrBestIdx: begin
                                prdata = apbDataT'(bestIdx);
                        end
                        default: begin
                                // Command, element and unmapped offsets
                                prdata = '0;
                        end
                endcase
        end

endmodule

//--- rtl/sadBestTracker.sv
`timescale 1ns/1ps

module sadBestTracker #(
        parameter int ElemWidth = 8
) (
        input  logic Clk,
        input  logic rst,

        input  logic [ElemWidth+3:0] sadSum,
        input  logic sumValid,
        input  logic clearBest,

        output logic [ElemWidth+3:0] lastSad,
        output logic [ElemWidth+3:0] bestSad,
        output sadPkg::frameIndexT bestIdx,
        output sadPkg::frameIndexT resultCount
);

        import sadPkg::*;

        frameIndexT nextCount;

        assign nextCount = resultCount + 1'b1;

        ////////////////////////////////////////
        // Result tracking
        ////////////////////////////////////////

        always_ff @(posedge Clk) begin
                if (rst) begin
                        lastSad <= '0;
                        bestSad <= '1;
                        bestIdx <= '0;
                        resultCount <= '0;
                end else begin
                        // Last result survives a clear
                        if (sumValid) begin
                                lastSad <= sadSum;
                        end

                        if (clearBest) begin
                                bestSad <= '1;
                                bestIdx <= '0;
                                resultCount <= '0;
                        end else if (sumValid) begin
                                resultCount <= nextCount;
                                // Ties keep the earlier index
                                if (sadSum < bestSad) begin
                                        bestSad <= sadSum;
                                        bestIdx <= resultCount;
                                end
                        end
                end
        end

endmodule

//--- rtl/sadDiffTree.sv
`timescale 1ns/1ps

module sadDiffTree #(
        parameter int ElemWidth = 8
) (
        input  logic Clk,
        input  logic rst,

        input  logic [sadPkg::NumElems*ElemWidth-1:0] windowVec,
        input  logic [sadPkg::NumElems*ElemWidth-1:0] frameVec,
        input  logic computeStrobe,

        output logic [ElemWidth+3:0] sadSum,
        output logic sumValid
);

        import sadPkg::*;

        localparam int SumWidth = ElemWidth + 4;
        localparam int GroupSize = 4;
        localparam int NumGroups = NumElems / GroupSize;
        // Four terms need two extra bits
        localparam int GroupWidth = ElemWidth + 2;

        logic [ElemWidth-1:0] absDiff [NumElems];
        logic [GroupWidth-1:0] partNext [NumGroups];
        logic [GroupWidth-1:0] partSum [NumGroups];
        logic [SumWidth-1:0] sumNext;
        logic diffValid;
        logic partValid;

        function automatic logic [ElemWidth-1:0] absDiffOf(
                input logic [ElemWidth-1:0] a,
                input logic [ElemWidth-1:0] b
        );
                return (a > b) ? (a - b) : (b - a);
        endfunction

        ////////////////////////////////////////
        // Stage 1, absolute differences
        ////////////////////////////////////////

        always_ff @(posedge Clk) begin
                for (int i = 0; i < NumElems; i++) begin
                        absDiff[i] <= absDiffOf(windowVec[i*ElemWidth +: ElemWidth],
                                                frameVec[i*ElemWidth +: ElemWidth]);
                end
        end

        ////////////////////////////////////////
        // Stage 2, partial sums
        ////////////////////////////////////////

        always_comb begin
                for (int g = 0; g < NumGroups; g++) begin
                        partNext[g] = '0;
                        for (int k = 0; k < GroupSize; k++) begin
                                partNext[g] = partNext[g] + GroupWidth'(absDiff[g*GroupSize + k]);
                        end
                end
        end

        always_ff @(posedge Clk) begin
                partSum <= partNext;
        end

        ////////////////////////////////////////
        // Stage 3, total
        ////////////////////////////////////////

        always_comb begin
                sumNext = '0;
                for (int g = 0; g < NumGroups; g++) begin
                        sumNext = sumNext + SumWidth'(partSum[g]);
                end
        end

        always_ff @(posedge Clk) begin
                sadSum <= sumNext;
        end

        // Valid bits follow the data stages
        always_ff @(posedge Clk) begin
                if (rst) begin
                        diffValid <= 1'b0;
                        partValid <= 1'b0;
                        sumValid <= 1'b0;
                end else begin
                        diffValid <= computeStrobe;
                        partValid <= diffValid;
                        sumValid <= partValid;
                end
        end

endmodule

//--- rtl/sadEngineTop.sv
`timescale 1ns/1ps

module sadEngineTop #(
        parameter int ElemWidth = 8
) (
        input  logic Clk,
        input  logic rst,

        input  logic psel,
        input  logic penable,
        input  logic pwrite,
        input  sadPkg::apbAddrT paddr,
        input  sadPkg::apbDataT pwdata,
        output sadPkg::apbDataT prdata
);

        import sadPkg::*;

        localparam int SumWidth = ElemWidth + 4;
        localparam int VecWidth = NumElems * ElemWidth;

        logic [VecWidth-1:0] stageVec;
        logic [VecWidth-1:0] windowVec;
        logic [VecWidth-1:0] frameVec;
        loadKindT loadKind;
        logic computeStrobe;
        logic [SumWidth-1:0] sadSum;
        logic sumValid;
        logic clearBest;
        logic [SumWidth-1:0] lastSad;
        logic [SumWidth-1:0] bestSad;
        frameIndexT bestIdx;
        frameIndexT resultCount;

        ////////////////////////////////////////
        // Host side
        ////////////////////////////////////////

        sadApbControl #(.ElemWidth(ElemWidth)) uControl (
                .Clk(Clk), .rst(rst),
                .psel(psel), .penable(penable), .pwrite(pwrite),
                .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
                .lastSad(lastSad), .bestSad(bestSad),
                .bestIdx(bestIdx), .resultCount(resultCount),
                .stageVec(stageVec), .loadKind(loadKind), .clearBest(clearBest)
        );

        ////////////////////////////////////////
        // Datapath
        ////////////////////////////////////////

        sadVectorCapture #(.ElemWidth(ElemWidth)) uCapture (
                .Clk(Clk), .rst(rst),
                .stageVec(stageVec), .loadKind(loadKind),
                .windowVec(windowVec), .frameVec(frameVec), .computeStrobe(computeStrobe)
        );

        sadDiffTree #(.ElemWidth(ElemWidth)) uDiffTree (
                .Clk(Clk), .rst(rst),
                .windowVec(windowVec), .frameVec(frameVec), .computeStrobe(computeStrobe),
                .sadSum(sadSum), .sumValid(sumValid)
        );

        sadBestTracker #(.ElemWidth(ElemWidth)) uTracker (
                .Clk(Clk), .rst(rst),
                .sadSum(sadSum), .sumValid(sumValid), .clearBest(clearBest),
                .lastSad(lastSad), .bestSad(bestSad),
                .bestIdx(bestIdx), .resultCount(resultCount)
        );

endmodule

//--- rtl/sadPkg.sv
package sadPkg;

        ////////////////////////////////////////
        // Bus widths
        ////////////////////////////////////////

        localparam int ApbAddrWidth = 8;
        localparam int ApbDataWidth = 32;
        localparam int FrameIndexWidth = 8;

        // Elements per vector, one bank row
        localparam int NumElems = 16;

        typedef logic [ApbAddrWidth-1:0] apbAddrT;
        typedef logic [ApbDataWidth-1:0] apbDataT;

        // Result index since the last clear
        typedef logic [FrameIndexWidth-1:0] frameIndexT;

        ////////////////////////////////////////
        // Load command codes
        ////////////////////////////////////////

        // Same coding as the SAD field of the processor pipeline
        typedef enum logic [1:0] {
                kindNone         = 2'd0,
                kindFrameLoad    = 2'd1,
                kindFrameCompute = 2'd2,
                kindWindowLoad   = 2'd3
        } loadKindT;

        ////////////////////////////////////////
        // Register map
        ////////////////////////////////////////

        // Command issue, kind in bits 1:0
        localparam apbAddrT AddrCmd = 8'h00;
        // Staging element write
        localparam apbAddrT AddrElem = 8'h04;
        // Result count, a write clears the best tracking
        localparam apbAddrT AddrCount = 8'h08;
        localparam apbAddrT AddrLast = 8'h0C;
        localparam apbAddrT AddrBest = 8'h10;
        localparam apbAddrT AddrBestIdx = 8'h14;

endpackage

//--- rtl/sadVectorCapture.sv
`timescale 1ns/1ps

module sadVectorCapture #(
        parameter int ElemWidth = 8
) (
        input  logic Clk,
        input  logic rst,

        input  logic [sadPkg::NumElems*ElemWidth-1:0] stageVec,
        input  sadPkg::loadKindT loadKind,

        output logic [sadPkg::NumElems*ElemWidth-1:0] windowVec,
        output logic [sadPkg::NumElems*ElemWidth-1:0] frameVec,
        output logic computeStrobe
);

        import sadPkg::*;

        ////////////////////////////////////////
        // Bank select
        ////////////////////////////////////////

        // Window on code 3, frame on codes 1 and 2
        always_ff @(posedge Clk) begin
                if (rst) begin
                        windowVec <= '0;
                        frameVec <= '0;
                end else begin
                        case (loadKind)
                                kindWindowLoad: begin
                                        windowVec <= stageVec;
                                end
                                kindFrameLoad, kindFrameCompute: begin
                                        frameVec <= stageVec;
                                end
                                default: begin
                                        // Hold both banks
                                        windowVec <= windowVec;
                                end
                        endcase
                end
        end

        ////////////////////////////////////////
        // Compute strobe
        ////////////////////////////////////////

        // Aligned with the new frame bank contents
        always_ff @(posedge Clk) begin
                if (rst) begin
                        computeStrobe <= 1'b0;
                end else begin
                        computeStrobe <= (loadKind == kindFrameCompute);
                end
        end

endmodule

//--- sadEngine.f
rtl/sadPkg.sv
rtl/sadApbControl.sv
rtl/sadVectorCapture.sv
rtl/sadDiffTree.sv
rtl/sadBestTracker.sv
rtl/sadEngineTop.sv
tb/sadEngine_assertions.sv
tb/sadEngineTb.sv

//--- tb/sadEngineTb.sv
`timescale 1ns/1ps

module sadEngineTb;

        import sadPkg::*;

        localparam int ElemWidth = 8;
        localparam int SumWidth = ElemWidth + 4;
        localparam int TimeoutCycles = 200;

        typedef logic [NumElems-1:0][ElemWidth-1:0] vecT;

        logic Clk;
        logic rst;
        logic psel;
        logic penable;
        logic pwrite;
        apbAddrT paddr;
        apbDataT pwdata;
        apbDataT prdata;

        integer seed = 32'h3cfc;
        int errorCount = 0;
        int checkCount = 0;
        int testCount = 0;
        int testFailCount = 0;
        int testStartErrors = 0;

        // Expected engine state
        vecT window;
        apbDataT modelLast;
        apbDataT modelBest;
        frameIndexT modelBestIdx;
        frameIndexT modelCount;

        // Reads waiting for comparison
        string nameQ[$];
        apbDataT expQ[$];
        apbDataT actQ[$];
        bit idxQ[$];

        sadEngineTop #(.ElemWidth(ElemWidth)) uut (
                .Clk(Clk), .rst(rst),
                .psel(psel), .penable(penable), .pwrite(pwrite),
                .paddr(paddr), .pwdata(pwdata), .prdata(prdata)
        );

        initial begin
                Clk = 1'b0;
                forever #10 Clk = ~Clk;
        end

        ////////////////////////////////////////
        // Reference and compare
        ////////////////////////////////////////

        function automatic apbDataT refSad(input vecT win, input vecT frm);
                apbDataT total;
                total = '0;
                for (int i = 0; i < NumElems; i++) begin
                        if (win[i] > frm[i]) begin
                                total += apbDataT'(win[i] - frm[i]);
                        end else begin
                                total += apbDataT'(frm[i] - win[i]);
                        end
                end
                return total;
        endfunction

        task automatic checkData(input string name, input apbDataT exp, input apbDataT act);
                checkCount++;
                if (act !== exp) begin
                        errorCount++;
                        $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                                 $time, name, exp, act);
                end
        endtask

        task automatic checkIndex(input string name, input frameIndexT exp,
                                  input frameIndexT act);
                checkCount++;
                if (act !== exp) begin
                        errorCount++;
                        $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                                 $time, name, exp, act);
                end
        endtask

        always @(posedge Clk) begin : compareResults
                string name;
                apbDataT expVal;
                apbDataT actVal;
                bit isIndex;
                while (actQ.size() > 0) begin
                        name = nameQ.pop_front();
                        expVal = expQ.pop_front();
                        actVal = actQ.pop_front();
                        isIndex = idxQ.pop_front();
                        if (isIndex) begin
                                checkIndex(name, frameIndexT'(expVal), frameIndexT'(actVal));
                        end else begin
                                checkData(name, expVal, actVal);
                        end
                end
        end

        ////////////////////////////////////////
        // APB master tasks start on a falling edge
        ////////////////////////////////////////

        task automatic waitForReset();
                int waited;
                waited = 0;
                while (rst && waited < TimeoutCycles) begin
                        @(negedge Clk);
                        waited++;
                end
                if (rst) begin
                        errorCount++;
                        $display("Timeout at %0t: reset never released", $time);
                end
        endtask

        task automatic apbWrite(input apbAddrT addr, input apbDataT data);
                waitForReset();
                psel = 1'b1;
                pwrite = 1'b1;
                paddr = addr;
                pwdata = data;
                @(negedge Clk);
                penable = 1'b1;
                @(negedge Clk);
                psel = 1'b0;
                penable = 1'b0;
                pwrite = 1'b0;
        endtask

        task automatic apbRead(input apbAddrT addr, output apbDataT data);
                waitForReset();
                psel = 1'b1;
                pwrite = 1'b0;
                paddr = addr;
                @(negedge Clk);
                penable = 1'b1;
                // Address settled a cycle ago so the value holds to the access edge
                data = prdata;
                @(negedge Clk);
                psel = 1'b0;
                penable = 1'b0;
        endtask

        ////////////////////////////////////////
        // Test helpers
        ////////////////////////////////////////

        task automatic makeRandomVec(output vecT v);
                for (int i = 0; i < NumElems; i++) begin
                        v[i] = ElemWidth'($random(seed));
                end
        endtask

        task automatic clearModel();
                modelBest = apbDataT'({SumWidth{1'b1}});
                modelBestIdx = '0;
                modelCount = '0;
        endtask

        // Ties keep the first index since only a smaller SAD wins
        task automatic modelCompute(input vecT frm);
                modelLast = refSad(window, frm);
                if (modelLast < modelBest) begin
                        modelBest = modelLast;
                        modelBestIdx = modelCount;
                end
                modelCount++;
        endtask

        task automatic issue(input loadKindT kind, input vecT v);
                for (int i = 0; i < NumElems; i++) begin
                        apbWrite(AddrElem, apbDataT'(v[i]));
                end
                apbWrite(AddrCmd, apbDataT'(kind));
                if (kind == kindWindowLoad) begin
                        window = v;
                end else if (kind == kindFrameCompute) begin
                        modelCompute(v);
                end
        endtask

        task automatic waitForCount(input frameIndexT target);
                apbDataT cnt;
                int polls;
                polls = 0;
                apbRead(AddrCount, cnt);
                while (frameIndexT'(cnt) != target && polls < TimeoutCycles) begin
                        apbRead(AddrCount, cnt);
                        polls++;
                end
                if (frameIndexT'(cnt) != target) begin
                        errorCount++;
                        $display("Timeout at %0t: result count stuck at %0d instead of %0d",
                                 $time, cnt, target);
                end
        endtask

        task automatic expectRead(input string name, input apbAddrT addr,
                                  input apbDataT exp, input bit isIndex);
                apbDataT act;
                apbRead(addr, act);
                nameQ.push_back(name);
                expQ.push_back(exp);
                idxQ.push_back(isIndex);
                actQ.push_back(act);
        endtask

        task automatic finishTest(input string name);
                int waited;
                waited = 0;
                while (actQ.size() > 0 && waited < TimeoutCycles) begin
                        @(negedge Clk);
                        waited++;
                end
                if (actQ.size() > 0) begin
                        errorCount++;
                        $display("Compare process left %0d reads unchecked", actQ.size());
                end
                testCount++;
                if (errorCount == testStartErrors) begin
                        $display("Test %0d, %s: ok", testCount, name);
                end else begin
                        testFailCount++;
                        $display("Test %0d, %s: %0d errors", testCount, name,
                                 errorCount - testStartErrors);
                end
                testStartErrors = errorCount;
        endtask

        ////////////////////////////////////////
        // Test sequence
        ////////////////////////////////////////

        initial begin
                vecT frm;
                rst = 1'b1;
                psel = 1'b0;
                penable = 1'b0;
                pwrite = 1'b0;
                paddr = '0;
                pwdata = '0;
                window = '0;
                modelLast = '0;
                clearModel();
                repeat (16) @(negedge Clk);
                rst = 1'b0;

                expectRead("resultCount", AddrCount, 0, 1'b1);
                expectRead("bestSad", AddrBest, modelBest, 1'b0);
                expectRead("lastSad", AddrLast, 0, 1'b0);
                finishTest("reset values");

                makeRandomVec(frm);
                issue(kindWindowLoad, frm);
                makeRandomVec(frm);
                issue(kindFrameCompute, frm);
                waitForCount(modelCount);
                expectRead("lastSad", AddrLast, modelLast, 1'b0);
                expectRead("resultCount", AddrCount, 1, 1'b1);
                finishTest("single compute");

                // Second pass does a frame load only
                for (int n = 0; n < 3; n++) begin
                        makeRandomVec(frm);
                        issue(kindFrameCompute, frm);
                        waitForCount(modelCount);
                        expectRead("lastSad", AddrLast, modelLast, 1'b0);
                        makeRandomVec(frm);
                        issue((n == 1) ? kindFrameLoad : kindWindowLoad, frm);
                end
                expectRead("resultCount", AddrCount, modelCount, 1'b1);
                finishTest("window changes and frame load");

                for (int n = 0; n < 6; n++) begin
                        makeRandomVec(frm);
                        // Window copy gives a zero SAD twice
                        if (n == 2 || n == 4) begin
                                frm = window;
                        end
                        issue(kindFrameCompute, frm);
                end
                waitForCount(modelCount);
                expectRead("bestSad", AddrBest, modelBest, 1'b0);
                expectRead("bestIdx", AddrBestIdx, modelBestIdx, 1'b1);
                finishTest("best and first index");

                // Zero best from above would mask this burst
                apbWrite(AddrCount, '0);
                clearModel();
                makeRandomVec(frm);
                issue(kindWindowLoad, frm);
                for (int n = 0; n < 4; n++) begin
                        makeRandomVec(frm);
                        issue(kindFrameCompute, frm);
                end
                waitForCount(modelCount);
                expectRead("lastSad", AddrLast, modelLast, 1'b0);
                expectRead("bestSad", AddrBest, modelBest, 1'b0);
                expectRead("bestIdx", AddrBestIdx, modelBestIdx, 1'b1);
                finishTest("back-to-back computes");

                apbWrite(AddrCount, '0);
                clearModel();
                waitForCount(0);
                expectRead("bestSad", AddrBest, modelBest, 1'b0);
                expectRead("bestIdx", AddrBestIdx, 0, 1'b1);
                makeRandomVec(frm);
                issue(kindFrameCompute, frm);
                waitForCount(1);
                expectRead("bestSad", AddrBest, modelLast, 1'b0);
                expectRead("bestIdx", AddrBestIdx, 0, 1'b1);
                finishTest("clear and restart");

                $display("Done: %0d tests, %0d failed, %0d checks, %0d errors",
                         testCount, testFailCount, checkCount, errorCount);
                if (errorCount == 0) begin
                        $display("SIMULATION PASSED");
                end else begin
                        $display("SIMULATION FAILED");
                end
                $finish;
        end

endmodule

//--- tb/sadEngine_assertions.sv
`timescale 1ns/1ps

module sadEngine_assertions (
        input logic Clk,
        input logic rst,
        input sadPkg::loadKindT loadKind,
        input logic computeStrobe,
        input logic sumValid,
        input logic clearBest
);

        import sadPkg::*;

        // Three tree stages, checked in both directions
        strobeToValid: assert property (@(posedge Clk) disable iff (rst)
                sumValid == $past(computeStrobe, 3))
                else $error("sumValid does not trail computeStrobe by 3 cycles");

        commandOneCycle: assert property (@(posedge Clk) disable iff (rst)
                (loadKind != kindNone) |=> (loadKind == kindNone))
                else $error("loadKind carried a command for two cycles");

        clearOneCycle: assert property (@(posedge Clk) disable iff (rst)
                clearBest |=> !clearBest)
                else $error("clearBest stayed high for more than one cycle");

endmodule

bind sadEngineTop sadEngine_assertions uAssertions (
        .Clk(Clk), .rst(rst), .loadKind(loadKind),
        .computeStrobe(computeStrobe), .sumValid(sumValid), .clearBest(clearBest)
);
